// File: include/hc_consts.svh
// Register map, buffer sizing and fold constants of the hash-command front end
// The prefix constant holds its first byte in the low bits
`ifndef HC_CONSTS_SVH
`define HC_CONSTS_SVH

// Bus widths
`define HC_APB_AW 12
`define HC_DATA_W 32

// Register byte offsets
`define HC_ADDR_CFG       12'h000
`define HC_ADDR_PREFIX_LO 12'h004
`define HC_ADDR_PREFIX_HI 12'h008
`define HC_ADDR_CMD       12'h00C
`define HC_ADDR_MSG       12'h010
`define HC_ADDR_STATUS    12'h014
`define HC_ADDR_ERR       12'h018
`define HC_ADDR_DIGEST    12'h01C

// Message buffer
`define HC_FIFO_DEPTH 8

// Digest fold
`define HC_DIGEST_SEED    32'h6A09E667
`define HC_ROT            5
`define HC_SQUEEZE_CONST  32'h9E3779B9
`define HC_SQUEEZE_CYCLES 4

// encode_string("KMAC") as bytes 01 20 4B 4D 41 43
`define HC_PREFIX_KMAC 48'h43414D4B2001

`endif

// File: rtl/hc_pkg.sv
// Shared types of the hash-command front end
// Enum widths are fixed because the error info field packs them directly
`include "hc_consts.svh"

package hc_pkg;

  // Software commands written to CMD
  typedef enum logic [2:0] {
    CmdNone      = 3'd0,
    CmdStart     = 3'd1,
    CmdProcess   = 3'd2,
    CmdManualRun = 3'd3,
    CmdDone      = 3'd4
  } hc_cmd_e;

  // Hash mode, value 1 is unused
  typedef enum logic [1:0] {
    Sha3   = 2'd0,
    Shake  = 2'd2,
    CShake = 2'd3
  } hc_mode_e;

  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } hc_strength_e;

  typedef enum logic [7:0] {
    ErrNone                   = 8'h00,
    ErrSwCmdSequence          = 8'h01,
    ErrUnexpectedModeStrength = 8'h02,
    ErrIncorrectFunctionName  = 8'h03
  } hc_err_code_e;

  // Command sequence state, shown in STATUS
  typedef enum logic [2:0] {
    StIdle       = 3'd0,
    StMsgFeed    = 3'd1,
    StProcessing = 3'd2,
    StAbsorbed   = 3'd3,
    StSqueezing  = 3'd4
  } hc_seq_st_e;

  // Configuration, 55 bits
  typedef struct packed {
    hc_mode_e     mode;
    hc_strength_e strength;
    logic         kmac_en;
    logic         allow_unsupported;
    logic [47:0]  prefix;
  } hc_cfg_t;

  typedef struct packed {
    logic         valid;
    hc_err_code_e code;
    logic [23:0]  info;
  } hc_err_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`HC_APB_AW-1:0] paddr;
    logic [`HC_DATA_W-1:0] pwdata;
  } hc_apb_req_t;

  typedef struct packed {
    logic [`HC_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } hc_apb_rsp_t;

endpackage : hc_pkg

// File: rtl/hc_msg_fifo.sv
// Show-ahead message FIFO, read data is valid whenever empty is low
// Pushes while full are ignored
`timescale 1ns/10ps
`include "hc_consts.svh"

module hc_msg_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  logic [`HC_DATA_W-1:0] wdata_i,
  input  logic                  pop_i,
  output logic [`HC_DATA_W-1:0] rdata_o,
  output logic                  full_o,
  output logic                  empty_o
);

  localparam int PtrW = $clog2(`HC_FIFO_DEPTH);
  localparam int CntW = $clog2(`HC_FIFO_DEPTH + 1);

  logic [`HC_DATA_W-1:0] mem [`HC_FIFO_DEPTH];
  logic [PtrW-1:0]       wr_ptr;
  logic [PtrW-1:0]       rd_ptr;
  logic [CntW-1:0]       count;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr] <= wdata_i;
  end

  // Pointers wrap at the last slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PtrW'(`HC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PtrW'(`HC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CntW'(do_push) - CntW'(do_pop);
    end
  end

  assign rdata_o = mem[rd_ptr];
  assign full_o  = (count == CntW'(`HC_FIFO_DEPTH));
  assign empty_o = (count == '0);

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule : hc_msg_fifo

// File: rtl/hc_apb_regs.sv
// APB register block with no wait state except a MSG write into a full FIFO
// Writes to unmapped offsets are dropped and answer with pslverr
`timescale 1ns/10ps
`include "hc_consts.svh"

module hc_apb_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  hc_pkg::hc_apb_req_t   apb_req_i,
  output hc_pkg::hc_apb_rsp_t   apb_rsp_o,
  output hc_pkg::hc_cfg_t       cfg_o,
  output hc_pkg::hc_cmd_e       sw_cmd_o,
  output logic                  push_o,
  output logic [`HC_DATA_W-1:0] wdata_o,
  input  logic                  full_i,
  input  hc_pkg::hc_err_t       err_i,
  input  hc_pkg::hc_seq_st_e    state_i,
  input  logic [`HC_DATA_W-1:0] digest_i
);

  logic                  access;
  logic                  wr;
  logic                  msg_wr;
  logic                  stall;
  logic                  mapped;
  logic [`HC_DATA_W-1:0] prdata;
  hc_pkg::hc_cfg_t       cfg_q;
  hc_pkg::hc_err_t       err_q;

  ////////////////////////////////////////
  // Transfer decode
  ////////////////////////////////////////

  // Access phase of an APB transfer
  assign access = apb_req_i.psel && apb_req_i.penable;
  assign wr     = access && apb_req_i.pwrite;
  assign msg_wr = wr && (apb_req_i.paddr == `HC_ADDR_MSG);

  // Hold the MSG write until the FIFO has room
  assign stall  = msg_wr && full_i;

  assign push_o  = msg_wr && !full_i;
  assign wdata_o = apb_req_i.pwdata;

  // One-cycle command pulse in the access cycle
  assign sw_cmd_o = (wr && (apb_req_i.paddr == `HC_ADDR_CMD)) ?
                    hc_pkg::hc_cmd_e'(apb_req_i.pwdata[2:0]) : hc_pkg::CmdNone;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (wr) begin
      case (apb_req_i.paddr)
        `HC_ADDR_CFG: begin
          cfg_q.mode              <= hc_pkg::hc_mode_e'(apb_req_i.pwdata[1:0]);
          cfg_q.strength          <= hc_pkg::hc_strength_e'(apb_req_i.pwdata[4:2]);
          cfg_q.kmac_en           <= apb_req_i.pwdata[8];
          cfg_q.allow_unsupported <= apb_req_i.pwdata[9];
        end
        `HC_ADDR_PREFIX_LO: cfg_q.prefix[31:0]  <= apb_req_i.pwdata;
        `HC_ADDR_PREFIX_HI: cfg_q.prefix[47:32] <= apb_req_i.pwdata[15:0];
        default: ;
      endcase
    end
  end

  assign cfg_o = cfg_q;

  // Sticky error record where the first error wins until ERR is written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= '0;
    end else if (wr && (apb_req_i.paddr == `HC_ADDR_ERR)) begin
      err_q <= '0;
    end else if (!err_q.valid && err_i.valid) begin
      err_q <= err_i;
    end
  end

  ////////////////////////////////////////
  // Read data and response
  ////////////////////////////////////////

  always_comb begin
    mapped = 1'b1;
    prdata = '0;
    case (apb_req_i.paddr)
      `HC_ADDR_CFG: begin
        prdata = {22'h0, cfg_q.allow_unsupported, cfg_q.kmac_en,
                  3'h0, cfg_q.strength, cfg_q.mode};
      end
      `HC_ADDR_PREFIX_LO: prdata = cfg_q.prefix[31:0];
      `HC_ADDR_PREFIX_HI: prdata = {16'h0, cfg_q.prefix[47:32]};
      `HC_ADDR_CMD: prdata = '0;
      `HC_ADDR_MSG: prdata = '0;
      // STATUS holds error valid, FIFO full and the sequence state
      `HC_ADDR_STATUS: prdata = {27'h0, err_q.valid, full_i, state_i};
      `HC_ADDR_ERR: prdata = {err_q.code, err_q.info};
      `HC_ADDR_DIGEST: prdata = digest_i;
      default: mapped = 1'b0;
    endcase
  end

  assign apb_rsp_o.prdata  = prdata;
  assign apb_rsp_o.pready  = access && !stall;
  assign apb_rsp_o.pslverr = access && !mapped;

  // The requester holds a stalled MSG write and its data until room frees
  a_stall_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall |=> msg_wr && $stable(apb_req_i.pwdata));

endmodule : hc_apb_regs

// File: rtl/hc_cmd_check.sv
// Command sequence tracker and configuration checker on the command path
// A prefix mismatch is only reported and never blocks the command
`timescale 1ns/10ps
`include "hc_consts.svh"

module hc_cmd_check (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  hc_pkg::hc_cfg_t    cfg_i,
  input  hc_pkg::hc_cmd_e    sw_cmd_i,
  input  logic               absorbed_i,
  input  logic               squeeze_done_i,
  output hc_pkg::hc_cmd_e    cmd_o,
  output hc_pkg::hc_seq_st_e state_o,
  output hc_pkg::hc_err_t    err_o
);

  hc_pkg::hc_seq_st_e st_q;
  hc_pkg::hc_seq_st_e st_d;
  logic               err_seq;
  logic               err_ms;
  logic               err_prefix;
  logic               pair_ok;
  logic               starting;
  logic               block;
  logic [2:0]         flags;

  ////////////////////////////////////////
  // Sequence check
  ////////////////////////////////////////

  // Legal commands per state with None accepted everywhere
  always_comb begin
    err_seq = 1'b0;
    case (st_q)
      hc_pkg::StIdle:
        err_seq = !(sw_cmd_i inside {hc_pkg::CmdNone, hc_pkg::CmdStart});
      hc_pkg::StMsgFeed:
        err_seq = !(sw_cmd_i inside {hc_pkg::CmdNone, hc_pkg::CmdProcess});
      hc_pkg::StAbsorbed:
        err_seq = !(sw_cmd_i inside {hc_pkg::CmdNone, hc_pkg::CmdManualRun,
                                     hc_pkg::CmdDone});
      // Processing and Squeezing accept no command
      default:
        err_seq = (sw_cmd_i != hc_pkg::CmdNone);
    endcase
  end

  // Next state before gating
  always_comb begin
    st_d = st_q;
    case (st_q)
      hc_pkg::StIdle:       if (sw_cmd_i == hc_pkg::CmdStart) st_d = hc_pkg::StMsgFeed;
      hc_pkg::StMsgFeed:    if (sw_cmd_i == hc_pkg::CmdProcess) st_d = hc_pkg::StProcessing;
      hc_pkg::StProcessing: if (absorbed_i) st_d = hc_pkg::StAbsorbed;
      hc_pkg::StAbsorbed: begin
        if (sw_cmd_i == hc_pkg::CmdManualRun) begin
          st_d = hc_pkg::StSqueezing;
        end else if (sw_cmd_i == hc_pkg::CmdDone) begin
          st_d = hc_pkg::StIdle;
        end
      end
      hc_pkg::StSqueezing:  if (squeeze_done_i) st_d = hc_pkg::StAbsorbed;
      default:              st_d = hc_pkg::StIdle;
    endcase
  end

  ////////////////////////////////////////
  // Configuration check at Start
  ////////////////////////////////////////

  assign starting = (st_q == hc_pkg::StIdle) && (st_d == hc_pkg::StMsgFeed);

  // Supported mode and strength pairs
  assign pair_ok =
    ((cfg_i.mode == hc_pkg::Sha3) &&
     (cfg_i.strength inside {hc_pkg::L224, hc_pkg::L256, hc_pkg::L384, hc_pkg::L512})) ||
    ((cfg_i.mode inside {hc_pkg::Shake, hc_pkg::CShake}) &&
     (cfg_i.strength inside {hc_pkg::L128, hc_pkg::L256}));

  assign err_ms     = starting && !pair_ok;
  assign err_prefix = starting && cfg_i.kmac_en && (cfg_i.prefix != `HC_PREFIX_KMAC);

  // Sequence errors always block and bad pairs block unless allowed
  assign block = err_seq || (err_ms && !cfg_i.allow_unsupported);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_o <= hc_pkg::CmdNone;
      st_q  <= hc_pkg::StIdle;
    end else begin
      cmd_o <= block ? hc_pkg::CmdNone : sw_cmd_i;
      if (!block) st_q <= st_d;
    end
  end

  assign state_o = st_q;

  // Error record by priority of sequence over mode over prefix
  assign flags = {err_seq, err_ms, err_prefix};

  always_comb begin
    err_o = '0;
    if (err_seq) begin
      err_o.valid = 1'b1;
      err_o.code  = hc_pkg::ErrSwCmdSequence;
      err_o.info  = {5'h0, flags, 5'h0, st_q, 5'h0, sw_cmd_i};
    end else if (err_ms) begin
      err_o.valid = 1'b1;
      err_o.code  = hc_pkg::ErrUnexpectedModeStrength;
      err_o.info  = {5'h0, flags, 6'h0, cfg_i.mode, 5'h0, cfg_i.strength};
    end else if (err_prefix) begin
      err_o.valid = 1'b1;
      err_o.code  = hc_pkg::ErrIncorrectFunctionName;
      err_o.info  = {5'h0, flags, 16'h0};
    end
  end

  a_state_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(st_q));

  // A forwarded command always moves the sequence on
  a_fwd_moves_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cmd_o != hc_pkg::CmdNone) |-> (st_q != $past(st_q)));

endmodule : hc_cmd_check

// File: rtl/hc_absorb_core.sv
// Stand-in absorb core, a rotate and XOR fold and not a real hash
// Commands are taken as legal, the checker filters them upstream
`timescale 1ns/10ps
`include "hc_consts.svh"

module hc_absorb_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  hc_pkg::hc_cmd_e       cmd_i,
  input  logic [`HC_DATA_W-1:0] rdata_i,
  input  logic                  empty_i,
  output logic                  pop_o,
  output logic                  absorbed_o,
  output logic                  squeeze_done_o,
  output logic [`HC_DATA_W-1:0] digest_o
);

  localparam int SqzW = $clog2(`HC_SQUEEZE_CYCLES);

  typedef enum logic [2:0] {
    CoreIdle,
    CoreFeed,
    CoreDrain,
    CoreAbsorbed,
    CoreSqueeze
  } core_st_e;

  core_st_e              st_q;
  logic [SqzW-1:0]       sqz_cnt;
  logic [`HC_DATA_W-1:0] digest_q;

  // Rotate left by HC_ROT, then XOR in the word
  function automatic logic [`HC_DATA_W-1:0] fold(input logic [`HC_DATA_W-1:0] d,
                                                 input logic [`HC_DATA_W-1:0] w);
    return ((d << `HC_ROT) | (d >> (`HC_DATA_W - `HC_ROT))) ^ w;
  endfunction

  // Drain while feeding and after Process
  assign pop_o          = ((st_q == CoreFeed) || (st_q == CoreDrain)) && !empty_i;
  assign absorbed_o     = (st_q == CoreDrain) && empty_i;
  assign squeeze_done_o = (st_q == CoreSqueeze) && (sqz_cnt == SqzW'(`HC_SQUEEZE_CYCLES - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q     <= CoreIdle;
      sqz_cnt  <= '0;
      digest_q <= '0;
    end else begin
      if (pop_o) digest_q <= fold(digest_q, rdata_i);
      case (st_q)
        CoreIdle: begin
          if (cmd_i == hc_pkg::CmdStart) begin
            digest_q <= `HC_DIGEST_SEED;
            st_q     <= CoreFeed;
          end
        end
        CoreFeed:  if (cmd_i == hc_pkg::CmdProcess) st_q <= CoreDrain;
        CoreDrain: if (empty_i) st_q <= CoreAbsorbed;
        CoreAbsorbed: begin
          if (cmd_i == hc_pkg::CmdManualRun) begin
            sqz_cnt <= '0;
            st_q    <= CoreSqueeze;
          end else if (cmd_i == hc_pkg::CmdDone) begin
            st_q <= CoreIdle;
          end
        end
        CoreSqueeze: begin
          sqz_cnt <= sqz_cnt + 1'b1;
          // Last round cycle folds the constant
          if (squeeze_done_o) begin
            digest_q <= fold(digest_q, `HC_SQUEEZE_CONST);
            st_q     <= CoreAbsorbed;
          end
        end
        default: st_q <= CoreIdle;
      endcase
    end
  end

  assign digest_o = digest_q;

endmodule : hc_absorb_core

// File: rtl/hc_top.sv
// Hash-command front end, APB port in, no interrupts
`timescale 1ns/10ps
`include "hc_consts.svh"

module hc_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  hc_pkg::hc_apb_req_t apb_req_i,
  output hc_pkg::hc_apb_rsp_t apb_rsp_o
);

  hc_pkg::hc_cfg_t       cfg;
  hc_pkg::hc_cmd_e       sw_cmd;
  hc_pkg::hc_cmd_e       cmd_fwd;
  hc_pkg::hc_err_t       err;
  hc_pkg::hc_seq_st_e    state;
  logic                  push;
  logic                  pop;
  logic                  full;
  logic                  empty;
  logic                  absorbed;
  logic                  squeeze_done;
  logic [`HC_DATA_W-1:0] wdata;
  logic [`HC_DATA_W-1:0] rdata;
  logic [`HC_DATA_W-1:0] digest;

  // Producer
  hc_apb_regs i_hc_apb_regs (
    .clk_i, .rst_ni, .apb_req_i, .apb_rsp_o,
    .cfg_o(cfg), .sw_cmd_o(sw_cmd), .push_o(push), .wdata_o(wdata),
    .full_i(full), .err_i(err), .state_i(state), .digest_i(digest)
  );

  // Command gate between producer and consumer
  hc_cmd_check i_hc_cmd_check (
    .clk_i, .rst_ni, .cfg_i(cfg), .sw_cmd_i(sw_cmd),
    .absorbed_i(absorbed), .squeeze_done_i(squeeze_done),
    .cmd_o(cmd_fwd), .state_o(state), .err_o(err)
  );

  hc_msg_fifo i_hc_msg_fifo (
    .clk_i, .rst_ni, .push_i(push), .wdata_i(wdata), .pop_i(pop),
    .rdata_o(rdata), .full_o(full), .empty_o(empty)
  );

  // Consumer
  hc_absorb_core i_hc_absorb_core (
    .clk_i, .rst_ni, .cmd_i(cmd_fwd), .rdata_i(rdata), .empty_i(empty),
    .pop_o(pop), .absorbed_o(absorbed), .squeeze_done_o(squeeze_done),
    .digest_o(digest)
  );

endmodule : hc_top

// File: tb/hc_checker.sv
// Bus monitor and scoreboard, models sequence state, sticky error and digest
// Assumes STATUS is polled between commands so Processing and Squeezing resolve
`timescale 1ns/10ps
`include "hc_consts.svh"

module hc_checker (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  hc_pkg::hc_apb_req_t apb_req_i,
  input  hc_pkg::hc_apb_rsp_t apb_rsp_i,
  output int                  errors_o,
  output int                  checks_o,
  output int                  stalls_o
);

  localparam logic [47:0] KmacPrefix = `HC_PREFIX_KMAC;

  logic [2:0]  st;
  logic [1:0]  mode;
  logic [2:0]  strength;
  logic        kmac_en;
  logic        allow;
  logic [47:0] prefix;
  logic        err_valid;
  logic [31:0] err_word;
  logic [31:0] digest;
  logic [31:0] pending [$];

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  // Rotate left through a doubled word, then XOR
  function automatic logic [31:0] ref_fold(input logic [31:0] d, input logic [31:0] w);
    logic [63:0] dd;
    dd = {d, d};
    return dd[63-`HC_ROT -: 32] ^ w;
  endfunction

  function automatic logic addr_mapped(input logic [11:0] a);
    return (a[1:0] == 2'b00) && (a <= `HC_ADDR_DIGEST);
  endfunction

  // Legal commands per sequence state
  function automatic logic cmd_legal(input logic [2:0] s, input logic [2:0] c);
    case (s)
      hc_pkg::StIdle:     return c == hc_pkg::CmdStart;
      hc_pkg::StMsgFeed:  return c == hc_pkg::CmdProcess;
      hc_pkg::StAbsorbed: return (c == hc_pkg::CmdManualRun) || (c == hc_pkg::CmdDone);
      default:            return 1'b0;
    endcase
  endfunction

  function automatic logic pair_ok(input logic [1:0] m, input logic [2:0] s);
    if (m == hc_pkg::Sha3) return s inside {hc_pkg::L224, hc_pkg::L256, hc_pkg::L384,
                                            hc_pkg::L512};
    if (m == hc_pkg::Shake || m == hc_pkg::CShake) return s inside {hc_pkg::L128, hc_pkg::L256};
    return 1'b0;
  endfunction

  function automatic logic [2:0] next_state(input logic [2:0] s, input logic [2:0] c);
    if (s == hc_pkg::StIdle && c == hc_pkg::CmdStart) return hc_pkg::StMsgFeed;
    if (s == hc_pkg::StMsgFeed && c == hc_pkg::CmdProcess) return hc_pkg::StProcessing;
    if (s == hc_pkg::StAbsorbed && c == hc_pkg::CmdManualRun) return hc_pkg::StSqueezing;
    if (s == hc_pkg::StAbsorbed && c == hc_pkg::CmdDone) return hc_pkg::StIdle;
    return s;
  endfunction

  // Expected error record {valid, code, info}, sequence before mode before prefix
  function automatic logic [32:0] err_rule(input logic [2:0] s, input logic [2:0] c);
    logic       seq;
    logic       ms;
    logic       pf;
    logic [2:0] flags;
    seq   = !cmd_legal(s, c);
    ms    = (s == hc_pkg::StIdle) && (c == hc_pkg::CmdStart) && !pair_ok(mode, strength);
    pf    = (s == hc_pkg::StIdle) && (c == hc_pkg::CmdStart) && kmac_en &&
            (prefix != KmacPrefix);
    flags = {seq, ms, pf};
    if (seq) return {1'b1, hc_pkg::ErrSwCmdSequence, 5'h0, flags, 5'h0, s, 5'h0, c};
    if (ms) return {1'b1, hc_pkg::ErrUnexpectedModeStrength, 5'h0, flags, 6'h0, mode,
                    5'h0, strength};
    if (pf) return {1'b1, hc_pkg::ErrIncorrectFunctionName, 5'h0, flags, 16'h0};
    return 33'h0;
  endfunction

  ////////////////////////////////////////
  // Model update and compare
  ////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks_o++;
    if (exp !== got) begin
      errors_o++;
      $display("Mismatch %s: expected 0x%08h, got 0x%08h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic handle_write(input logic [11:0] addr, input logic [31:0] data);
    logic [2:0]  c;
    logic [32:0] e;
    logic        blocked;
    c = data[2:0];
    case (addr)
      `HC_ADDR_CFG: begin
        mode     = data[1:0];
        strength = data[4:2];
        kmac_en  = data[8];
        allow    = data[9];
      end
      `HC_ADDR_PREFIX_LO: prefix[31:0] = data;
      `HC_ADDR_PREFIX_HI: prefix[47:32] = data[15:0];
      `HC_ADDR_ERR: err_valid = 1'b0;
      `HC_ADDR_MSG: begin
        // Core folds only while feeding or draining, else the word waits
        if (st == hc_pkg::StMsgFeed || st == hc_pkg::StProcessing) digest = ref_fold(digest, data);
        else pending.push_back(data);
      end
      `HC_ADDR_CMD: begin
        e = err_rule(st, c);
        if (e[32] && !err_valid) begin
          err_valid = 1'b1;
          err_word  = e[31:0];
        end
        blocked = !cmd_legal(st, c) ||
                  ((e[31:24] == hc_pkg::ErrUnexpectedModeStrength) && !allow);
        if (!blocked) begin
          if (c == hc_pkg::CmdStart) begin
            digest = `HC_DIGEST_SEED;
            while (pending.size() > 0) digest = ref_fold(digest, pending.pop_front());
          end
          if (c == hc_pkg::CmdManualRun) digest = ref_fold(digest, `HC_SQUEEZE_CONST);
          st = next_state(st, c);
        end
      end
      default: ;
    endcase
  endtask

  task automatic handle_read(input logic [11:0] addr, input logic [31:0] data);
    case (addr)
      `HC_ADDR_STATUS: begin
        // Hardware ends Processing and Squeezing on its own
        if ((st == hc_pkg::StProcessing || st == hc_pkg::StSqueezing) &&
            data[2:0] == hc_pkg::StAbsorbed) st = hc_pkg::StAbsorbed;
        compare("STATUS.state", 32'(st), 32'(data[2:0]));
        compare("STATUS.err_valid", 32'(err_valid), 32'(data[4]));
      end
      `HC_ADDR_ERR: compare("ERR", err_valid ? err_word : 32'h0, data);
      `HC_ADDR_DIGEST: if (st == hc_pkg::StAbsorbed) compare("DIGEST", digest, data);
      default: ;
    endcase
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      st        = hc_pkg::StIdle;
      {mode, strength, kmac_en, allow, prefix} = '0;
      err_valid = 1'b0;
      err_word  = '0;
      digest    = '0;
      pending.delete();
      errors_o  = 0;
      checks_o  = 0;
      stalls_o  = 0;
    end else if (apb_req_i.psel && apb_req_i.penable) begin
      if (!apb_rsp_i.pready) begin
        if (apb_req_i.pwrite && apb_req_i.paddr == `HC_ADDR_MSG) begin
          stalls_o++;
        end else begin
          errors_o++;
          $display("Wait state on a transfer other than a MSG write at %0t", $time);
        end
      end else begin
        compare("pslverr", 32'(!addr_mapped(apb_req_i.paddr)), 32'(apb_rsp_i.pslverr));
        if (apb_req_i.pwrite) handle_write(apb_req_i.paddr, apb_req_i.pwdata);
        else handle_read(apb_req_i.paddr, apb_rsp_i.prdata);
      end
    end
  end

endmodule : hc_checker

// File: tb/tb_hc_top.sv
// Testbench for the hash-command front end, one APB transfer at a time
// Transfers run back to back so a MSG write can meet the FIFO still full
`timescale 1ns/10ps
`include "hc_consts.svh"

module tb_hc_top;

  localparam int          ClkPeriod    = 8;
  localparam int          PlannedXfers = 160;
  localparam logic [47:0] KmacPrefix   = `HC_PREFIX_KMAC;

  logic                clk;
  logic                rst_n;
  hc_pkg::hc_apb_req_t apb_req;
  hc_pkg::hc_apb_rsp_t apb_rsp;
  logic [31:0]         rng;
  logic [31:0]         rdata;
  int                  chk_errors;
  int                  chk_checks;
  int                  stalls;
  int                  tb_errors;

  hc_top i_hc_top (.clk_i(clk), .rst_ni(rst_n), .apb_req_i(apb_req), .apb_rsp_o(apb_rsp));

  hc_checker i_hc_checker (
    .clk_i(clk), .rst_ni(rst_n), .apb_req_i(apb_req), .apb_rsp_i(apb_rsp),
    .errors_o(chk_errors), .checks_o(chk_checks), .stalls_o(stalls)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  ////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////

  // Entered and left 1 ns after a rising edge, pready sampled on the falling edge
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) @(negedge clk);
    rdata = apb_rsp.prdata;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    apb_xfer(1'b1, addr, data);
  endtask

  task automatic read_reg(input logic [11:0] addr);
    apb_xfer(1'b0, addr, 32'h0);
  endtask

  task automatic send_cmd(input hc_pkg::hc_cmd_e cmd);
    write_reg(`HC_ADDR_CMD, 32'(cmd));
  endtask

  task automatic set_cfg(input logic [1:0] mode, input logic [2:0] strength,
                         input logic kmac, input logic allow);
    write_reg(`HC_ADDR_CFG, {22'h0, allow, kmac, 3'h0, strength, mode});
  endtask

  // Poll STATUS, the watchdog bounds the loop
  task automatic wait_state(input hc_pkg::hc_seq_st_e st);
    read_reg(`HC_ADDR_STATUS);
    while (rdata[2:0] != st) read_reg(`HC_ADDR_STATUS);
  endtask

  task automatic push_words(input int n);
    for (int i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      write_reg(`HC_ADDR_MSG, rng);
    end
  endtask

  task automatic absorb_and_read();
    send_cmd(hc_pkg::CmdProcess);
    wait_state(hc_pkg::StAbsorbed);
    read_reg(`HC_ADDR_DIGEST);
    read_reg(`HC_ADDR_ERR);
  endtask

  task automatic finish_hash();
    send_cmd(hc_pkg::CmdDone);
    wait_state(hc_pkg::StIdle);
  endtask

  // Read state and error record, then clear the record
  task automatic read_and_clear_err();
    read_reg(`HC_ADDR_STATUS);
    read_reg(`HC_ADDR_ERR);
    write_reg(`HC_ADDR_ERR, 32'h0);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    apb_req   = '0;
    rst_n     = 1'b0;
    rng       = 32'he9f587e8;
    rdata     = '0;
    tb_errors = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Legal flow with fewer words than the FIFO holds
    set_cfg(hc_pkg::Sha3, hc_pkg::L256, 1'b0, 1'b0);
    send_cmd(hc_pkg::CmdStart);
    rng = xorshift32(rng);
    push_words(1 + int'(rng % (`HC_FIFO_DEPTH - 1)));
    absorb_and_read();
    finish_hash();

    // Fill the FIFO in Idle, the first word after Start meets it full
    push_words(`HC_FIFO_DEPTH);
    send_cmd(hc_pkg::CmdStart);
    rng = xorshift32(rng);
    push_words(1 + int'(rng % `HC_FIFO_DEPTH));
    absorb_and_read();

    // Squeeze on the absorbed digest
    send_cmd(hc_pkg::CmdManualRun);
    wait_state(hc_pkg::StAbsorbed);
    read_reg(`HC_ADDR_DIGEST);
    finish_hash();

    // Out-of-order commands
    send_cmd(hc_pkg::CmdProcess);
    read_and_clear_err();
    send_cmd(hc_pkg::CmdStart);
    absorb_and_read();
    send_cmd(hc_pkg::CmdStart);
    read_and_clear_err();
    finish_hash();

    // Unsupported pair, blocked then allowed
    set_cfg(hc_pkg::Shake, hc_pkg::L512, 1'b0, 1'b0);
    send_cmd(hc_pkg::CmdStart);
    read_and_clear_err();
    set_cfg(hc_pkg::Shake, hc_pkg::L512, 1'b0, 1'b1);
    send_cmd(hc_pkg::CmdStart);
    read_and_clear_err();
    absorb_and_read();
    finish_hash();

    // Wrong then correct function-name prefix
    write_reg(`HC_ADDR_PREFIX_LO, KmacPrefix[31:0] ^ 32'h1);
    write_reg(`HC_ADDR_PREFIX_HI, {16'h0, KmacPrefix[47:32]});
    set_cfg(hc_pkg::Sha3, hc_pkg::L512, 1'b1, 1'b0);
    send_cmd(hc_pkg::CmdStart);
    read_and_clear_err();
    push_words(2);
    absorb_and_read();
    finish_hash();
    write_reg(`HC_ADDR_PREFIX_LO, KmacPrefix[31:0]);
    send_cmd(hc_pkg::CmdStart);
    push_words(3);
    absorb_and_read();
    finish_hash();

    // Unmapped offsets
    write_reg(12'h100, 32'hDEAD_BEEF);
    read_reg(12'h020);

    if (stalls == 0) begin
      tb_errors++;
      $display("No MSG write was held off by a full FIFO");
    end
    $display("Checks %0d, checker errors %0d, testbench errors %0d, stall cycles %0d",
             chk_checks, chk_errors, tb_errors, stalls);
    if (chk_errors + tb_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the planned transfer count
  initial begin
    #(PlannedXfers * 40 * ClkPeriod);
    $display("Timeout after %0d cycles, the DUT stopped answering", PlannedXfers * 40);
    $display("Simulation failed");
    $finish;
  end

endmodule : tb_hc_top

// File: files.f
+incdir+include
rtl/hc_pkg.sv
rtl/hc_msg_fifo.sv
rtl/hc_apb_regs.sv
rtl/hc_cmd_check.sv
rtl/hc_absorb_core.sv
rtl/hc_top.sv
tb/hc_checker.sv
tb/tb_hc_top.sv

// File: Makefile
# Verilator flow for the hash-command front end
TOP := tb_hc_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
	  echo "Run reported failure"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" sim.log; then \
	  echo "Run ended without a result line"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
